// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = filter_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, then run; a $fatal or failed assertion gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
src/video_pkg.sv
src/constant_pad.sv
src/window_3x3.sv
src/kernel_filter.sv
src/filter_top.sv
test/filter_checker.sv
test/filter_tb.sv

// ==== src/constant_pad.sv ====
`timescale 1ns/1ns

module constant_pad (
    input  logic                  clock_i,
    input  logic                  reset_i,

    // Original pixels in
    input  logic                  s_valid_i,
    output logic                  s_ready_o,
    input  video_pkg::pixel_beat_t s_beat_i,

    // Padded pixels out
    output logic                  m_valid_o,
    input  logic                  m_ready_i,
    output video_pkg::pixel_beat_t m_beat_o
);

    ////////////////////////////////////////
    // Position in the padded frame
    ////////////////////////////////////////

    // Position of the pixel currently offered downstream
    video_pkg::pad_pos_t pos_q;

    // Current position lies in the border
    logic in_border;
    // Current position is the final padded pixel
    logic at_last;
    // Output beat accepted this cycle
    logic out_xfer;

    // Border is everything outside the original image
    assign in_border =
        pos_q.row < video_pkg::pad_row_t'(video_pkg::PADDING) ||
        pos_q.row >= video_pkg::pad_row_t'(video_pkg::IN_HEIGHT + video_pkg::PADDING) ||
        pos_q.col < video_pkg::pad_col_t'(video_pkg::PADDING) ||
        pos_q.col >= video_pkg::pad_col_t'(video_pkg::IN_WIDTH + video_pkg::PADDING);

    assign at_last =
        pos_q.row == video_pkg::pad_row_t'(video_pkg::PAD_HEIGHT - 1) &&
        pos_q.col == video_pkg::pad_col_t'(video_pkg::PAD_WIDTH - 1);

    assign out_xfer = m_valid_o && m_ready_i;

    // Counter only moves when a padded pixel leaves
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pos_q <= '0;
        end else if (out_xfer) begin
            pos_q <= video_pkg::next_pad_pos(pos_q);
        end
    end

    ////////////////////////////////////////
    // Stream muxing
    ////////////////////////////////////////

    // Border pixels need no input, image pixels wait for one
    assign m_valid_o = in_border || s_valid_i;

    // Input is only consumed at image positions
    // Held off while the pipeline is in reset
    assign s_ready_o = !reset_i && !in_border && m_ready_i;

    // Fill value in the border, otherwise pass through
    // Incoming last is ignored, the counter marks the frame end
    assign m_beat_o.data = in_border ? video_pkg::PAD_VALUE : s_beat_i.data;
    assign m_beat_o.last = at_last;

endmodule : constant_pad

// ==== src/filter_top.sv ====
`timescale 1ns/1ns

module filter_top (
    input  logic                   clock_i,
    input  logic                   reset_i,

    // Kernel for the current frame
    input  video_pkg::kernel_mode_e kernel_mode_i,

    // Raw pixel stream
    input  logic                   s_valid_i,
    output logic                   s_ready_o,
    input  video_pkg::pixel_beat_t  s_beat_i,

    // Filtered pixel stream
    output logic                   m_valid_o,
    input  logic                   m_ready_i,
    output video_pkg::pixel_beat_t  m_beat_o
);

    ////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////

    // Pad to window
    logic pad_valid;
    logic pad_ready;
    video_pkg::pixel_beat_t pad_beat;

    // Window to kernel
    logic win_valid;
    logic win_ready;
    video_pkg::window_beat_t win_beat;

    // Border generation, zero latency
    constant_pad u_constant_pad (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .s_valid_i (s_valid_i),
        .s_ready_o (s_ready_o),
        .s_beat_i  (s_beat_i),
        .m_valid_o (pad_valid),
        .m_ready_i (pad_ready),
        .m_beat_o  (pad_beat)
    );

    // Neighbourhood builder, one register stage
    window_3x3 u_window_3x3 (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .s_valid_i (pad_valid),
        .s_ready_o (pad_ready),
        .s_beat_i  (pad_beat),
        .m_valid_o (win_valid),
        .m_ready_i (win_ready),
        .m_beat_o  (win_beat)
    );

    // Convolution, one register stage
    kernel_filter u_kernel_filter (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .kernel_mode_i (kernel_mode_i),
        .s_valid_i     (win_valid),
        .s_ready_o     (win_ready),
        .s_beat_i      (win_beat),
        .m_valid_o     (m_valid_o),
        .m_ready_i     (m_ready_i),
        .m_beat_o      (m_beat_o)
    );

endmodule : filter_top

// ==== src/kernel_filter.sv ====
`timescale 1ns/1ns

module kernel_filter (
    input  logic                   clock_i,
    input  logic                   reset_i,

    // Kernel for the current frame
    input  video_pkg::kernel_mode_e kernel_mode_i,

    // Neighbourhoods in
    input  logic                   s_valid_i,
    output logic                   s_ready_o,
    input  video_pkg::window_beat_t s_beat_i,

    // Filtered pixels out
    output logic                   m_valid_o,
    input  logic                   m_ready_i,
    output video_pkg::pixel_beat_t  m_beat_o
);

    // Shorthand for the incoming neighbourhood
    video_pkg::window_t win;

    // Weighted sum for the 1-2-1 kernel
    video_pkg::blur_sum_t blur_sum;
    // Sum of the eight neighbours and eight times the centre
    video_pkg::blur_sum_t neighbour_sum;
    video_pkg::blur_sum_t centre_x8;
    // Laplacian before clamping
    video_pkg::edge_sum_t edge_diff;

    video_pkg::pixel_t blur_pixel;
    video_pkg::pixel_t edge_pixel;
    video_pkg::pixel_t result;

    logic accept;

    // Output register
    logic out_valid_q;
    video_pkg::pixel_beat_t out_beat_q;

    assign win = s_beat_i.window;

    ////////////////////////////////////////
    // Kernel arithmetic
    ////////////////////////////////////////

    always_comb begin
        // Corners weight 1, edges 2, centre 4
        blur_sum = video_pkg::blur_sum_t'(win[0]) + video_pkg::blur_sum_t'(win[2]) +
                   video_pkg::blur_sum_t'(win[6]) + video_pkg::blur_sum_t'(win[8]) +
                   ((video_pkg::blur_sum_t'(win[1]) + video_pkg::blur_sum_t'(win[3]) +
                     video_pkg::blur_sum_t'(win[5]) + video_pkg::blur_sum_t'(win[7])) << 1) +
                   (video_pkg::blur_sum_t'(win[4]) << 2);
        // Normalise by 16
        blur_pixel = blur_sum[video_pkg::BLUR_SUM_WIDTH-1:video_pkg::BLUR_SHIFT];

        neighbour_sum = video_pkg::blur_sum_t'(win[0]) + video_pkg::blur_sum_t'(win[1]) +
                        video_pkg::blur_sum_t'(win[2]) + video_pkg::blur_sum_t'(win[3]) +
                        video_pkg::blur_sum_t'(win[5]) + video_pkg::blur_sum_t'(win[6]) +
                        video_pkg::blur_sum_t'(win[7]) + video_pkg::blur_sum_t'(win[8]);
        centre_x8 = video_pkg::blur_sum_t'(win[4]) << 3;
        // Both operands are non-negative, widen by a zero bit
        edge_diff = video_pkg::edge_sum_t'({1'b0, centre_x8}) -
                    video_pkg::edge_sum_t'({1'b0, neighbour_sum});

        // Clamp to the pixel range
        if (edge_diff < 0) begin
            edge_pixel = '0;
        end else if (edge_diff > video_pkg::edge_sum_t'(video_pkg::PIXEL_MAX)) begin
            edge_pixel = video_pkg::PIXEL_MAX;
        end else begin
            edge_pixel = edge_diff[video_pkg::DATA_WIDTH-1:0];
        end
    end

    // Mode select, unused code falls back to the centre pixel
    always_comb begin
        case (kernel_mode_i)
            video_pkg::KERNEL_BLUR: result = blur_pixel;
            video_pkg::KERNEL_EDGE: result = edge_pixel;
            default: result = win[4];
        endcase
    end

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////

    assign s_ready_o = !out_valid_q || m_ready_i;
    assign accept = s_valid_i && s_ready_o;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (accept) begin
            out_valid_q <= 1'b1;
        end else if (m_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Result and frame end move together
    always_ff @(posedge clock_i) begin
        if (accept) begin
            out_beat_q.data <= result;
            out_beat_q.last <= s_beat_i.last;
        end
    end

    assign m_valid_o = out_valid_q;
    assign m_beat_o = out_beat_q;

endmodule : kernel_filter

// ==== src/video_pkg.sv ====
package video_pkg;

    ////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////

    // Bits per pixel
    localparam int DATA_WIDTH = 8;

    // Input frame size, kept small for quick simulation
    localparam int IN_HEIGHT = 6;
    localparam int IN_WIDTH = 8;

    // Border width, one pixel around a 3x3 window
    localparam int PADDING = 1;

    // Frame size after padding
    localparam int PAD_HEIGHT = IN_HEIGHT + 2 * PADDING;
    localparam int PAD_WIDTH = IN_WIDTH + 2 * PADDING;

    // Counter widths over the padded frame
    localparam int PAD_ROW_WIDTH = $clog2(PAD_HEIGHT);
    localparam int PAD_COL_WIDTH = $clog2(PAD_WIDTH);

    // Pixels in one 3x3 neighbourhood
    localparam int WINDOW_PIXELS = 9;

    // Blur weights sum to 16, so the normalising shift is 4
    localparam int BLUR_SHIFT = 4;
    localparam int BLUR_SUM_WIDTH = DATA_WIDTH + BLUR_SHIFT;
    // One extra bit for the sign of the Laplacian
    localparam int EDGE_SUM_WIDTH = BLUR_SUM_WIDTH + 1;

    ////////////////////////////////////////
    // Pixel and stream types
    ////////////////////////////////////////

    typedef logic [DATA_WIDTH-1:0] pixel_t;

    // Border fill value and upper clamp limit
    localparam pixel_t PAD_VALUE = '0;
    localparam pixel_t PIXEL_MAX = '1;

    // Row-major neighbourhood; 0 is top-left, 4 is the centre
    typedef pixel_t [WINDOW_PIXELS-1:0] window_t;

    typedef logic [BLUR_SUM_WIDTH-1:0] blur_sum_t;
    typedef logic signed [EDGE_SUM_WIDTH-1:0] edge_sum_t;

    // One pixel on a stream link
    typedef struct packed {
        pixel_t data;
        logic last;
    } pixel_beat_t;

    // One neighbourhood on a stream link
    typedef struct packed {
        window_t window;
        logic last;
    } window_beat_t;

    // Kernel selection, held stable for a whole frame
    typedef enum logic [1:0] {
        KERNEL_IDENTITY = 2'd0,
        KERNEL_BLUR = 2'd1,
        KERNEL_EDGE = 2'd2
    } kernel_mode_e;

    ////////////////////////////////////////
    // Padded frame position
    ////////////////////////////////////////

    typedef logic [PAD_ROW_WIDTH-1:0] pad_row_t;
    typedef logic [PAD_COL_WIDTH-1:0] pad_col_t;

    typedef struct packed {
        pad_row_t row;
        pad_col_t col;
    } pad_pos_t;

    // Row-major step through the padded frame, wrapping at the end
    function automatic pad_pos_t next_pad_pos(pad_pos_t pos);
        pad_pos_t nxt_pos;
        nxt_pos = pos;
        if (pos.col == pad_col_t'(PAD_WIDTH - 1)) begin
            nxt_pos.col = '0;
            if (pos.row == pad_row_t'(PAD_HEIGHT - 1)) begin
                nxt_pos.row = '0;
            end else begin
                nxt_pos.row = pos.row + 1'b1;
            end
        end else begin
            nxt_pos.col = pos.col + 1'b1;
        end
        return nxt_pos;
    endfunction

endpackage : video_pkg

// ==== src/window_3x3.sv ====
`timescale 1ns/1ns

module window_3x3 (
    input  logic                   clock_i,
    input  logic                   reset_i,

    // Padded pixels in
    input  logic                   s_valid_i,
    output logic                   s_ready_o,
    input  video_pkg::pixel_beat_t  s_beat_i,

    // One neighbourhood per original pixel out
    output logic                   m_valid_o,
    input  logic                   m_ready_i,
    output video_pkg::window_beat_t m_beat_o
);

    // Padded position of the next pixel to accept
    video_pkg::pad_pos_t pos_q;

    // Previous two padded rows, indexed by column
    // line_top_q is two rows up, line_mid_q one row up
    video_pkg::pixel_t line_top_q [video_pkg::PAD_WIDTH];
    video_pkg::pixel_t line_mid_q [video_pkg::PAD_WIDTH];

    // Two older window columns, [row][0] is the leftmost
    video_pkg::pixel_t hist_q [3][2];

    // Column arriving with the accepted pixel, top to bottom
    video_pkg::pixel_t col_new [3];

    // Window that ends at the accepted pixel
    video_pkg::window_t window_next;

    logic accept;
    logic window_done;

    // Output register
    logic out_valid_q;
    video_pkg::window_beat_t out_beat_q;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Room when empty or draining this cycle
    assign s_ready_o = !out_valid_q || m_ready_i;
    assign accept = s_valid_i && s_ready_o;

    // A full window exists once two rows and two columns are behind
    assign window_done =
        pos_q.row >= video_pkg::pad_row_t'(2 * video_pkg::PADDING) &&
        pos_q.col >= video_pkg::pad_col_t'(2 * video_pkg::PADDING);

    ////////////////////////////////////////
    // Window assembly
    ////////////////////////////////////////

    always_comb begin
        col_new[0] = line_top_q[pos_q.col];
        col_new[1] = line_mid_q[pos_q.col];
        col_new[2] = s_beat_i.data;
        // Row-major, two history columns then the new one
        for (int r = 0; r < 3; r++) begin
            window_next[3 * r]     = hist_q[r][0];
            window_next[3 * r + 1] = hist_q[r][1];
            window_next[3 * r + 2] = col_new[r];
        end
    end

    // Line buffers roll down one row, history shifts left
    always_ff @(posedge clock_i) begin
        if (accept) begin
            line_top_q[pos_q.col] <= line_mid_q[pos_q.col];
            line_mid_q[pos_q.col] <= s_beat_i.data;
            for (int r = 0; r < 3; r++) begin
                hist_q[r][0] <= hist_q[r][1];
                hist_q[r][1] <= col_new[r];
            end
        end
    end

    // Own copy of the padded position, stepped per accepted pixel
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            pos_q <= '0;
        end else if (accept) begin
            pos_q <= video_pkg::next_pad_pos(pos_q);
        end
    end

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////

    // Pixels that complete no window leave the register alone
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (accept && window_done) begin
            out_valid_q <= 1'b1;
        end else if (m_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Frame end rides on the window of the final padded pixel
    always_ff @(posedge clock_i) begin
        if (accept && window_done) begin
            out_beat_q.window <= window_next;
            out_beat_q.last <= s_beat_i.last;
        end
    end

    assign m_valid_o = out_valid_q;
    assign m_beat_o = out_beat_q;

endmodule : window_3x3

// ==== test/filter_checker.sv ====
`timescale 1ns/1ns

module filter_checker (
    input logic                    clock_i,
    input logic                    reset_i,
    input logic                    s_ready_i,
    input logic                    m_valid_i,
    input logic                    m_ready_i,
    input video_pkg::pixel_beat_t  m_beat_i,
    input logic                    win_valid_i,
    input logic                    win_ready_i,
    input video_pkg::window_beat_t win_beat_i
);

    ////////////////////////////////////////
    // Reset behaviour
    ////////////////////////////////////////

    // Output is empty from the second reset cycle up to the first free cycle
    assert property (@(posedge clock_i) reset_i |=> !m_valid_i)
        else $error("Output valid high during or right after reset");

    // No pixel may be taken while in reset
    assert property (@(posedge clock_i) reset_i |-> !s_ready_i)
        else $error("Input ready high during reset");

    ////////////////////////////////////////
    // Stream rules on the output link
    ////////////////////////////////////////

    // A stalled beat stays put
    assert property (@(posedge clock_i) disable iff (reset_i)
        m_valid_i && !m_ready_i |=> $stable(m_beat_i))
        else $error("Output beat changed while stalled");

    // Valid only drops after a transfer
    assert property (@(posedge clock_i) disable iff (reset_i)
        m_valid_i && !m_ready_i |=> m_valid_i)
        else $error("Output valid dropped without a transfer");

    // Same rules on the window to kernel link
    assert property (@(posedge clock_i) disable iff (reset_i)
        win_valid_i && !win_ready_i |=> win_valid_i && $stable(win_beat_i))
        else $error("Window beat not held while stalled");

endmodule : filter_checker

// ==== test/filter_tb.sv ====
`timescale 1ns/1ns

module filter_tb;

    localparam int IN_PIXELS = video_pkg::IN_HEIGHT * video_pkg::IN_WIDTH;
    // Cycle limit for one frame, far above the worst stall pattern
    localparam int FRAME_TIMEOUT = 5000;

    logic                    clock_i;
    logic                    reset_i;
    video_pkg::kernel_mode_e kernel_mode_i;
    logic                    s_valid_i;
    logic                    s_ready_o;
    video_pkg::pixel_beat_t  s_beat_i;
    logic                    m_valid_o;
    logic                    m_ready_i;
    video_pkg::pixel_beat_t  m_beat_o;

    integer seed;
    // Current source frame and the scoreboard queue
    video_pkg::pixel_t frame_pix [video_pkg::IN_HEIGHT][video_pkg::IN_WIDTH];
    int expected_q [$];

    filter_top u_filter_top (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .kernel_mode_i (kernel_mode_i),
        .s_valid_i     (s_valid_i),
        .s_ready_o     (s_ready_o),
        .s_beat_i      (s_beat_i),
        .m_valid_o     (m_valid_o),
        .m_ready_i     (m_ready_i),
        .m_beat_o      (m_beat_o)
    );

    bind filter_top filter_checker u_filter_checker (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .s_ready_i   (s_ready_o),
        .m_valid_i   (m_valid_o),
        .m_ready_i   (m_ready_i),
        .m_beat_i    (m_beat_o),
        .win_valid_i (win_valid),
        .win_ready_i (win_ready),
        .win_beat_i  (win_beat)
    );

    always #50 clock_i = ~clock_i;

    ////////////////////////////////////////
    // Failure handling and checks
    ////////////////////////////////////////

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string test_name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s: expected %0d, actual %0d", test_name, expected, actual);
            stop_run();
        end
    endtask

    // True with a probability of pct percent
    function automatic logic chance(input int pct);
        int r;
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Pixel of the padded frame, border reads as the fill value
    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || r >= video_pkg::IN_HEIGHT || c < 0 || c >= video_pkg::IN_WIDTH) begin
            return int'(video_pkg::PAD_VALUE);
        end
        return int'(frame_pix[r][c]);
    endfunction

    function automatic int model_pixel(input video_pkg::kernel_mode_e mode, input int r,
                                       input int c);
        int acc;
        int weight;
        acc = 0;
        case (mode)
            video_pkg::KERNEL_BLUR: begin
                // Separable 1-2-1 weights, total 16
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        weight = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                        acc += weight * pixel_at(r + dr, c + dc);
                    end
                end
                return acc / 16;
            end
            video_pkg::KERNEL_EDGE: begin
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dr == 0 && dc == 0) acc += 8 * pixel_at(r, c);
                        else acc -= pixel_at(r + dr, c + dc);
                    end
                end
                if (acc < 0) return 0;
                if (acc > 255) return 255;
                return acc;
            end
            default: return pixel_at(r, c);
        endcase
    endfunction

    task automatic fill_random();
        for (int r = 0; r < video_pkg::IN_HEIGHT; r++) begin
            for (int c = 0; c < video_pkg::IN_WIDTH; c++) begin
                frame_pix[r][c] = video_pkg::pixel_t'($random(seed));
            end
        end
    endtask

    task automatic fill_const(input int value);
        for (int r = 0; r < video_pkg::IN_HEIGHT; r++) begin
            for (int c = 0; c < video_pkg::IN_WIDTH; c++) begin
                frame_pix[r][c] = video_pkg::pixel_t'(value);
            end
        end
    endtask

    ////////////////////////////////////////
    // Stream driver and monitor
    ////////////////////////////////////////

    task automatic apply_reset();
        @(posedge clock_i);
        reset_i <= 1'b1;
        s_valid_i <= 1'b0;
        m_ready_i <= 1'b0;
        repeat (8) @(posedge clock_i);
        reset_i <= 1'b0;
    endtask

    // Sends the first n_pixels of the frame, holding each beat until taken
    task automatic drive_frame(input string test_name, input int n_pixels, input int gap_pct);
        int idx;
        int cycles;
        logic xfer;
        logic offer;
        idx = 0;
        cycles = 0;
        while (idx < n_pixels) begin
            @(posedge clock_i);
            xfer = s_valid_i && s_ready_o;
            if (xfer) idx++;
            offer = s_valid_i && !xfer;
            if (!offer && idx < n_pixels && !chance(gap_pct)) offer = 1'b1;
            s_valid_i <= offer;
            if (idx < n_pixels) begin
                s_beat_i.data <= frame_pix[idx / video_pkg::IN_WIDTH][idx % video_pkg::IN_WIDTH];
                s_beat_i.last <= (idx == IN_PIXELS - 1);
            end
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                $display("Timeout in %s: input pixels were not accepted", test_name);
                stop_run();
            end
        end
    endtask

    // Takes one frame of output with random back-pressure, checking each beat
    task automatic collect_frame(input string test_name, input int stall_pct);
        int count;
        int cycles;
        int expected;
        count = 0;
        cycles = 0;
        while (count < IN_PIXELS) begin
            @(posedge clock_i);
            if (m_valid_o && m_ready_i) begin
                if (expected_q.size() == 0) begin
                    $display("Error in %s: output beat arrived with none expected", test_name);
                    stop_run();
                end else begin
                    expected = expected_q.pop_front();
                    check_value({test_name, " data"}, expected, int'(m_beat_o.data));
                    check_value({test_name, " last"}, int'(count == IN_PIXELS - 1),
                                int'(m_beat_o.last));
                    count++;
                end
            end
            m_ready_i <= !chance(stall_pct);
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                $display("Timeout in %s: only %0d output pixels arrived", test_name, count);
                stop_run();
            end
        end
    endtask

    // Nothing further may come out once a frame is complete
    task automatic check_idle(input string test_name);
        m_ready_i <= 1'b1;
        repeat (16) begin
            @(posedge clock_i);
            check_value({test_name, " extra beat"}, 0, int'(m_valid_o));
        end
    endtask

    task automatic run_frame(input string test_name, input video_pkg::kernel_mode_e mode,
                             input int gap_pct, input int stall_pct);
        kernel_mode_i <= mode;
        for (int r = 0; r < video_pkg::IN_HEIGHT; r++) begin
            for (int c = 0; c < video_pkg::IN_WIDTH; c++) begin
                expected_q.push_back(model_pixel(mode, r, c));
            end
        end
        fork
            drive_frame(test_name, IN_PIXELS, gap_pct);
            collect_frame(test_name, stall_pct);
        join
        check_idle(test_name);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        seed = 32'h312d_8582;
        clock_i = 1'b0;
        reset_i = 1'b1;
        kernel_mode_i = video_pkg::KERNEL_IDENTITY;
        s_valid_i = 1'b0;
        s_beat_i = '0;
        m_ready_i = 1'b0;
        apply_reset();

        fill_random();
        run_frame("identity no stalls", video_pkg::KERNEL_IDENTITY, 0, 0);
        fill_random();
        run_frame("blur with stalls", video_pkg::KERNEL_BLUR, 30, 30);

        // Random, saturating and flat frames for the Laplacian
        fill_random();
        run_frame("edge random", video_pkg::KERNEL_EDGE, 30, 30);
        fill_const(255);
        run_frame("edge all 255", video_pkg::KERNEL_EDGE, 30, 30);
        fill_const(0);
        run_frame("edge all 0", video_pkg::KERNEL_EDGE, 30, 30);

        // Back to back frames, one mode each
        fill_random();
        run_frame("sequence frame 1", video_pkg::KERNEL_EDGE, 30, 30);
        fill_random();
        run_frame("sequence frame 2", video_pkg::KERNEL_IDENTITY, 30, 30);
        fill_random();
        run_frame("sequence frame 3", video_pkg::KERNEL_BLUR, 30, 30);

        // Abandon a frame part way, then start clean
        fill_random();
        kernel_mode_i <= video_pkg::KERNEL_BLUR;
        m_ready_i <= 1'b1;
        drive_frame("partial frame", 20, 30);
        apply_reset();
        fill_random();
        run_frame("after reset", video_pkg::KERNEL_EDGE, 30, 30);

        $display("all tests passed");
        $finish;
    end

endmodule : filter_tb
